// File: src/icache_settings.svh
// cache geometry is fixed at one word per line; tag width and line count derive from the rest
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address and instruction word width
`define ICACHE_ADDR_W 32

// 128 direct-mapped lines
`define ICACHE_INDEX_W 7

// byte offset inside the single-word line
`define ICACHE_OFFSET_W 2

// whatever is left above index and offset
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// one line per index value
`define ICACHE_LINES (1 << `ICACHE_INDEX_W)

// top nibble selects the address region
`define ICACHE_REGION_W 4

// fetches from this region always go to memory
`define ICACHE_UNCACHED_REGION 4'hA

`endif

// File: src/icache_pkg.sv
// shared types only; field widths come from the settings header and must sum to the address width
`include "icache_settings.svh"

package icache_pkg;

  // line view of a fetch address
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]    tag;
    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_OFFSET_W-1:0] offset;
  } line_view_t;

  // region view, used for the bypass decision
  typedef struct packed {
    logic [`ICACHE_REGION_W-1:0]                 region;
    logic [`ICACHE_ADDR_W-`ICACHE_REGION_W-1:0] rest;
  } region_view_t;

  // one address, decoded two ways
  typedef union packed {
    line_view_t   line;
    region_view_t map;
  } fetch_addr_u;

  // controller FSM
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_LOOKUP   = 3'd1,
    ST_REFILL   = 3'd2,
    ST_UNCACHED = 3'd3
  } ctrl_state_e;

endpackage

// File: src/line_access_if.sv
// arrays read combinationally at the held address; fill_en is a single-cycle write to both arrays
`timescale 1ns/1ns
`include "icache_settings.svh"

interface line_access_if;

  // registered fetch address from the controller
  icache_pkg::fetch_addr_u addr;

  // line fields seen by the arrays
  logic [`ICACHE_INDEX_W-1:0] index;
  logic [`ICACHE_TAG_W-1:0]   tag;

  // fill pulse and the word to store
  logic                       fill_en;
  logic [`ICACHE_ADDR_W-1:0]  fill_data;

  // lookup results
  logic                       hit;
  logic [`ICACHE_ADDR_W-1:0]  rd_data;

  // index and tag always follow the held address
  assign index = addr.line.index;
  assign tag   = addr.line.tag;

  modport ctrl (output addr, fill_en, fill_data, input hit, rd_data);

  modport tag_side (input index, tag, fill_en, output hit);

  modport data_side (input index, fill_en, fill_data, output rd_data);

endinterface

// File: src/icache_tag_store.sv
// valid bits clear on rst; a fill always marks the line valid, there is no invalidate path
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tag_store (
  input logic          clk,
  input logic          rst,
  line_access_if.tag_side la
);

  // per-line valid flags
  logic [`ICACHE_LINES-1:0] valid_q;

  // stored tags, guarded by valid_q
  logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_LINES];

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (la.fill_en) begin
      valid_q[la.index] <= 1'b1;
    end
  end

  // tag array, written with the same pulse
  always_ff @(posedge clk) begin
    if (la.fill_en) begin
      tag_mem[la.index] <= la.tag;
    end
  end

  // hit follows index with no added latency
  assign la.hit = valid_q[la.index] && (tag_mem[la.index] == la.tag);

  // a fill needs a known line to write
  a_fill_index_known : assert property (
    @(posedge clk) disable iff (rst)
    la.fill_en |-> !$isunknown(la.index)
  ) else $error("tag store fill with unknown index");

endmodule

// File: src/icache_data_store.sv
// no reset on the words; content is only trusted where the tag store has the valid bit set
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_data_store (
  input logic           clk,
  line_access_if.data_side la
);

  // one instruction word per line
  logic [`ICACHE_ADDR_W-1:0] data_mem [`ICACHE_LINES];

  // written on the fill pulse
  always_ff @(posedge clk) begin
    if (la.fill_en) begin
      data_mem[la.index] <= la.fill_data;
    end
  end

  // combinational read at the held index
  assign la.rd_data = data_mem[la.index];

endmodule

// File: src/icache_ctrl.sv
// one fetch in flight; requester holds address and valid until the data-valid pulse
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  // fetch side
  input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
  input  logic                      fetch_valid_i,
  output logic [`ICACHE_ADDR_W-1:0] fetch_data_o,
  output logic                      fetch_data_valid_o,
  // memory read port
  output logic [`ICACHE_ADDR_W-1:0] mem_araddr_o,
  output logic                      mem_arvalid_o,
  input  logic                      mem_arready_i,
  input  logic                      mem_rvalid_i,
  input  logic [`ICACHE_ADDR_W-1:0] mem_rdata_i,
  output logic                      mem_rready_o,
  // arrays
  line_access_if.ctrl               la
);

  icache_pkg::ctrl_state_e state_q;

  // held fetch address
  icache_pkg::fetch_addr_u addr_q;

  // result word and its pulse
  logic [`ICACHE_ADDR_W-1:0] data_q;
  logic                      data_valid_q;

  // fill pulse, same cycle as the data-valid pulse
  logic                      fill_q;

  logic                      accept;
  logic                      uncached;
  logic                      rd_take;
  logic [`ICACHE_ADDR_W-1:0] line_addr;

  // no new fetch during the result pulse
  // the requester still shows the old request in that cycle
  assign accept = (state_q == icache_pkg::ST_IDLE) && fetch_valid_i && !data_valid_q;

  // bypass decided from the region view
  assign uncached = (addr_q.map.region == `ICACHE_UNCACHED_REGION);

  // word address of the line, offset cleared
  assign line_addr = {addr_q.line.tag, addr_q.line.index, {`ICACHE_OFFSET_W{1'b0}}};

  // response counts only once the address is taken, same cycle allowed
  assign rd_take = mem_rvalid_i && mem_rready_o && (!mem_arvalid_o || mem_arready_i);

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= icache_pkg::ST_IDLE;
      mem_arvalid_o <= 1'b0;
      mem_rready_o  <= 1'b0;
      data_valid_q  <= 1'b0;
      fill_q        <= 1'b0;
    end else begin
      // both pulses last one cycle
      data_valid_q <= 1'b0;
      fill_q       <= 1'b0;
      case (state_q)
        icache_pkg::ST_IDLE: begin
          if (accept) begin
            state_q <= icache_pkg::ST_LOOKUP;
          end
        end
        icache_pkg::ST_LOOKUP: begin
          if (uncached) begin
            // uncached wins even over a stray tag match
            state_q       <= icache_pkg::ST_UNCACHED;
            mem_arvalid_o <= 1'b1;
            mem_rready_o  <= 1'b1;
          end else if (la.hit) begin
            state_q      <= icache_pkg::ST_IDLE;
            data_valid_q <= 1'b1;
          end else begin
            state_q       <= icache_pkg::ST_REFILL;
            mem_arvalid_o <= 1'b1;
            mem_rready_o  <= 1'b1;
          end
        end
        icache_pkg::ST_REFILL, icache_pkg::ST_UNCACHED: begin
          // address phase ends on arready
          if (mem_arvalid_o && mem_arready_i) begin
            mem_arvalid_o <= 1'b0;
          end
          if (rd_take) begin
            mem_rready_o  <= 1'b0;
            data_valid_q  <= 1'b1;
            // only cached misses write the arrays
            fill_q        <= (state_q == icache_pkg::ST_REFILL);
            state_q       <= icache_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= icache_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // address and data registers
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
    if (state_q == icache_pkg::ST_LOOKUP) begin
      // exact address for bypass, line-aligned for refill
      mem_araddr_o <= uncached ? addr_q : line_addr;
      if (la.hit && !uncached) begin
        data_q <= la.rd_data;
      end
    end
    if (rd_take) begin
      data_q <= mem_rdata_i;
    end
  end

  // result path
  assign fetch_data_o       = data_q;
  assign fetch_data_valid_o = data_valid_q;

  // arrays see the held address and the returned word
  assign la.addr      = addr_q;
  assign la.fill_en   = fill_q;
  assign la.fill_data = data_q;

  // request must not move while waiting for arready
  a_araddr_stable : assert property (
    @(posedge clk) disable iff (rst)
    mem_arvalid_o && !mem_arready_i |=> mem_arvalid_o && $stable(mem_araddr_o)
  ) else $error("read request changed before acceptance");

  // one pulse per access
  a_single_pulse : assert property (
    @(posedge clk) disable iff (rst)
    fetch_data_valid_o |=> !fetch_data_valid_o
  ) else $error("fetch data valid held for two cycles");

  // bypassed words never reach the arrays
  a_no_uncached_fill : assert property (
    @(posedge clk) disable iff (rst)
    la.fill_en |-> !uncached
  ) else $error("fill for an uncached address");

endmodule

// File: src/icache_top.sv
// single-beat read port only; caller must hold fetch_valid_i and fetch_addr_i until the result
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_top (
  input  logic                      clk,
  input  logic                      rst,
  // fetch side
  input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
  input  logic                      fetch_valid_i,
  output logic [`ICACHE_ADDR_W-1:0] fetch_data_o,
  output logic                      fetch_data_valid_o,
  // memory read port
  output logic [`ICACHE_ADDR_W-1:0] mem_araddr_o,
  output logic                      mem_arvalid_o,
  input  logic                      mem_arready_i,
  input  logic                      mem_rvalid_i,
  input  logic [`ICACHE_ADDR_W-1:0] mem_rdata_i,
  output logic                      mem_rready_o
);

  // lookup and fill path shared by the controller and both arrays
  line_access_if u_line_if ();

  // FSM, memory port, result select
  icache_ctrl u_ctrl (
    .clk                (clk),
    .rst                (rst),
    .fetch_addr_i       (fetch_addr_i),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_data_o       (fetch_data_o),
    .fetch_data_valid_o (fetch_data_valid_o),
    .mem_araddr_o       (mem_araddr_o),
    .mem_arvalid_o      (mem_arvalid_o),
    .mem_arready_i      (mem_arready_i),
    .mem_rvalid_i       (mem_rvalid_i),
    .mem_rdata_i        (mem_rdata_i),
    .mem_rready_o       (mem_rready_o),
    .la                 (u_line_if.ctrl)
  );

  // valid bits and tags, hit compare
  icache_tag_store u_tag_store (
    .clk (clk),
    .rst (rst),
    .la  (u_line_if.tag_side)
  );

  // line words
  icache_data_store u_data_store (
    .clk (clk),
    .la  (u_line_if.data_side)
  );

endmodule

// File: test/icache_tb.sv
// one fetch and one memory read outstanding at a time; cache behavior is checked against a local model
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tb;

  localparam int RANDOM_FETCHES   = 2000;
  localparam int DIRECTED_FETCHES = 14;
  localparam int TOTAL_FETCHES    = RANDOM_FETCHES + DIRECTED_FETCHES;
  localparam int RESET_CYCLES     = 10;
  localparam int CLK_PERIOD       = 40;
  localparam int FETCH_LIMIT      = 40;
  localparam int POOL_SIZE        = 12;
  // 20 cycles per fetch, plus reset
  localparam longint WATCHDOG_NS  =
    longint'(TOTAL_FETCHES * 20 + RESET_CYCLES) * longint'(CLK_PERIOD);

  logic                      clk;
  logic                      rst;
  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i;
  logic                      fetch_valid_i;
  logic [`ICACHE_ADDR_W-1:0] fetch_data_o;
  logic                      fetch_data_valid_o;
  logic [`ICACHE_ADDR_W-1:0] mem_araddr_o;
  logic                      mem_arvalid_o;
  logic                      mem_arready_i;
  logic                      mem_rvalid_i;
  logic [`ICACHE_ADDR_W-1:0] mem_rdata_i;
  logic                      mem_rready_o;

  // memory side bookkeeping
  int          read_count;
  int          uncached_serial;
  logic [31:0] last_read_addr;

  // reference model state
  logic                     model_valid [`ICACHE_LINES];
  logic [`ICACHE_TAG_W-1:0] model_tag   [`ICACHE_LINES];
  int                       model_reads;
  int                       model_serial;
  int                       fail_count;
  logic [31:0]              pool [POOL_SIZE];

  icache_top u_icache_top (
    .clk                (clk),
    .rst                (rst),
    .fetch_addr_i       (fetch_addr_i),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_data_o       (fetch_data_o),
    .fetch_data_valid_o (fetch_data_valid_o),
    .mem_araddr_o       (mem_araddr_o),
    .mem_arvalid_o      (mem_arvalid_o),
    .mem_arready_i      (mem_arready_i),
    .mem_rvalid_i       (mem_rvalid_i),
    .mem_rdata_i        (mem_rdata_i),
    .mem_rready_o       (mem_rready_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_count++;
      $display("[ERROR] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  // memory content: fixed per address, uncached words also move with each read
  function automatic logic [31:0] mem_word(input logic [31:0] addr, input logic [31:0] serial);
    logic [31:0] h;
    h = addr * 32'h9e37_79b1;
    h = h ^ {addr[15:0], addr[31:16]};
    return h ^ (serial * 32'h85eb_ca6b);
  endfunction

  function automatic bit is_uncached(input logic [31:0] addr);
    return addr[`ICACHE_ADDR_W-1 -: `ICACHE_REGION_W] == `ICACHE_UNCACHED_REGION;
  endfunction

  function automatic logic [31:0] make_addr(input logic [31:0] tag, input logic [31:0] idx,
                                            input logic [31:0] off);
    return (tag << (`ICACHE_INDEX_W + `ICACHE_OFFSET_W)) | (idx << `ICACHE_OFFSET_W) | off;
  endfunction

  // model step: read or not, at which address, and the word returned
  task automatic predict_fetch(input logic [31:0] addr, output bit exp_read,
                               output logic [31:0] exp_addr, output logic [31:0] exp_data);
    logic [`ICACHE_INDEX_W-1:0] idx;
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic [31:0]                line_addr;
    idx       = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    tag       = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    line_addr = addr & ~((32'd1 << `ICACHE_OFFSET_W) - 32'd1);
    if (is_uncached(addr)) begin
      model_serial++;
      exp_read = 1'b1;
      exp_addr = addr;
      exp_data = mem_word(addr, model_serial);
    end else if (model_valid[idx] && model_tag[idx] == tag) begin
      exp_read = 1'b0;
      exp_addr = line_addr;
      exp_data = mem_word(line_addr, 32'd0);
    end else begin
      // miss fills the line
      exp_read         = 1'b1;
      exp_addr         = line_addr;
      exp_data         = mem_word(line_addr, 32'd0);
      model_valid[idx] = 1'b1;
      model_tag[idx]   = tag;
    end
    if (exp_read) model_reads++;
  endtask

  // called at a falling edge with the cache idle
  task automatic do_fetch(input logic [31:0] addr, output bit did_read);
    bit          exp_read;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    int          reads_before;
    int          cycles;
    predict_fetch(addr, exp_read, exp_addr, exp_data);
    reads_before  = read_count;
    fetch_addr_i  = addr;
    fetch_valid_i = 1'b1;
    cycles        = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > FETCH_LIMIT) abort_run("fetch got no data valid pulse in time");
    end while (!fetch_data_valid_o);
    check_value("fetch_data_o", exp_data, fetch_data_o);
    check_value("memory reads per fetch", 32'(exp_read), 32'(read_count - reads_before));
    if (exp_read) begin
      check_value("mem_araddr_o", exp_addr, last_read_addr);
    end else begin
      // hit: accept edge, lookup, then the pulse
      check_value("hit latency", 32'd2, 32'(cycles));
    end
    did_read = (read_count != reads_before);
    // requester keeps the request up through the pulse cycle
    @(negedge clk);
    fetch_valid_i = 1'b0;
  endtask

  // memory responder, single beat, random delays
  initial begin : mem_responder
    int          ar_delay;
    int          r_delay;
    logic [31:0] req_addr;
    logic [31:0] rsp_data;
    mem_arready_i   = 1'b0;
    mem_rvalid_i    = 1'b0;
    mem_rdata_i     = '0;
    read_count      = 0;
    uncached_serial = 0;
    last_read_addr  = '0;
    forever begin
      @(negedge clk);
      if (!rst && mem_arvalid_o) begin
        req_addr       = mem_araddr_o;
        read_count++;
        last_read_addr = req_addr;
        check_value("mem_rready_o", 32'd1, 32'(mem_rready_o));
        if (is_uncached(req_addr)) begin
          uncached_serial++;
          rsp_data = mem_word(req_addr, uncached_serial);
        end else begin
          rsp_data = mem_word(req_addr, 32'd0);
        end
        ar_delay = int'($urandom_range(7, 0));
        r_delay  = int'($urandom_range(7, 0));
        // request must sit still until arready
        repeat (ar_delay) begin
          @(negedge clk);
          check_value("mem_arvalid_o", 32'd1, 32'(mem_arvalid_o));
          check_value("mem_araddr_o", req_addr, mem_araddr_o);
        end
        mem_arready_i = 1'b1;
        if (r_delay == 0) begin
          // response in the same cycle as address acceptance
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = rsp_data;
        end
        @(negedge clk);
        mem_arready_i = 1'b0;
        // address phase is over once arready was seen
        check_value("mem_arvalid_o", 32'd0, 32'(mem_arvalid_o));
        if (r_delay != 0) begin
          repeat (r_delay - 1) @(negedge clk);
          check_value("mem_rready_o", 32'd1, 32'(mem_rready_o));
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = rsp_data;
          @(negedge clk);
        end
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = ~rsp_data;
        // rready drops with the taken response
        check_value("mem_rready_o", 32'd0, 32'(mem_rready_o));
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run("watchdog expired, the run timed out before all fetches finished");
  end

  initial begin : main_seq
    bit          did_read;
    logic [31:0] rnd_addr;
    void'($urandom(32'h7b6d6207));
    fail_count    = 0;
    model_reads   = 0;
    model_serial  = 0;
    foreach (model_valid[i]) model_valid[i] = 1'b0;
    rst           = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // quiet outputs out of reset
    check_value("mem_arvalid_o", 32'd0, 32'(mem_arvalid_o));
    check_value("mem_rready_o", 32'd0, 32'(mem_rready_o));
    check_value("fetch_data_valid_o", 32'd0, 32'(fetch_data_valid_o));

    // first fetch misses, repeat hits
    do_fetch(32'h0000_1236, did_read);
    check_value("first fetch read", 32'd1, 32'(did_read));
    do_fetch(32'h0000_1236, did_read);
    check_value("repeat fetch read", 32'd0, 32'(did_read));

    // same index, two tags; third line elsewhere stays
    do_fetch(32'h0002_0400, did_read);
    repeat (2) begin
      do_fetch(32'h0001_1234, did_read);
      check_value("conflict fetch read", 32'd1, 32'(did_read));
      do_fetch(32'h0000_1234, did_read);
      check_value("conflict fetch read", 32'd1, 32'(did_read));
    end
    do_fetch(32'h0002_0400, did_read);
    check_value("other index read", 32'd0, 32'(did_read));

    // uncached never fills
    repeat (3) begin
      do_fetch(32'hA000_0A41, did_read);
      check_value("uncached fetch read", 32'd1, 32'(did_read));
    end
    do_fetch(32'h0000_0A40, did_read);
    check_value("cached after uncached read", 32'd1, 32'(did_read));
    // an uncached read at the same index leaves the filled line alone
    do_fetch(32'hA000_0A41, did_read);
    check_value("uncached fetch read", 32'd1, 32'(did_read));
    do_fetch(32'h0000_0A40, did_read);
    check_value("cached line kept", 32'd0, 32'(did_read));

    // small pool: three indexes, a few tags, some uncached
    for (int p = 0; p < POOL_SIZE; p++) begin
      rnd_addr = make_addr($urandom_range(3, 0), $urandom_range(3, 1), $urandom_range(3, 0));
      if (p < 3) rnd_addr = rnd_addr | (32'(`ICACHE_UNCACHED_REGION) << 28);
      pool[p] = rnd_addr;
    end
    repeat (RANDOM_FETCHES) begin
      rnd_addr      = pool[$urandom_range(POOL_SIZE - 1, 0)];
      rnd_addr[1:0] = 2'($urandom_range(3, 0));
      do_fetch(rnd_addr, did_read);
    end

    check_value("total memory reads", 32'(model_reads), 32'(read_count));
    if (fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+src
src/icache_pkg.sv
src/line_access_if.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_ctrl.sv
src/icache_top.sv
test/icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator; the log decides pass or fail
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module icache_tb -o icache_sim

# a fatal check gives a nonzero exit, the log search below still decides
./obj_dir/icache_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "testbench reported a failure"
  exit 1
fi

echo "testbench finished cleanly"
exit 0
